//--- exu.f
+incdir+sim
src/isa_pkg.sv
src/pipe_pkg.sv
src/exu_handshake.sv
src/alu.sv
src/exu_operand_stage.sv
src/exu_sideband.sv
src/exu_perf.sv
src/exu.sv
sim/exu_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the exu testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module exu_tb -f exu.f

status=0
./obj_dir/Vexu_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Some tests failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result line, see sim.log"
    exit 1
fi
echo "simulation clean"

//--- sim/exu_vectors.svh
// one row per instruction
// op1, op2, alu op, inv, kill, rd, funct3, ctrl, expected ex_result
// ctrl is {csr_wen[3:0], reg_wen, mem_wen, mem_ren, jump, branch, fetch_i}

typedef struct packed {
    logic [xlen-1:0]        op1;
    logic [xlen-1:0]        op2;
    alu_op_t                op;
    logic                   inv;
    logic                   kill;
    logic [reg_idx_w-1:0]   rd;
    logic [funct3_w-1:0]    funct3;
    logic [csr_wen_w+5:0]   ctrl;
    logic [xlen-1:0]        exp;
} vector_t;

localparam int n_vec = 28;

localparam vector_t vectors [n_vec] = '{
    '{32'h00000007, 32'h00000005, alu_add,    1'b0, 1'b0, 5'd1,  3'd0, 10'h020, 32'h0000000c},
    '{32'hffffffff, 32'h00000001, alu_add,    1'b0, 1'b0, 5'd2,  3'd0, 10'h020, 32'h00000000},
    '{32'h00000005, 32'h00000007, alu_sub,    1'b0, 1'b0, 5'd3,  3'd0, 10'h020, 32'hfffffffe},
    '{32'h80000000, 32'h00000001, alu_sub,    1'b0, 1'b0, 5'd4,  3'd0, 10'h020, 32'h7fffffff},
    // shifts, amounts above 31 keep only the low five bits
    '{32'h00000001, 32'h0000001f, alu_sll,    1'b0, 1'b0, 5'd5,  3'd1, 10'h020, 32'h80000000},
    '{32'h00000003, 32'h00000024, alu_sll,    1'b0, 1'b0, 5'd6,  3'd1, 10'h020, 32'h00000030},
    '{32'h80000000, 32'h00000004, alu_srl,    1'b0, 1'b0, 5'd7,  3'd5, 10'h020, 32'h08000000},
    '{32'hf0000000, 32'h0000003c, alu_srl,    1'b0, 1'b0, 5'd8,  3'd5, 10'h020, 32'h0000000f},
    '{32'h80000000, 32'h00000004, alu_sra,    1'b0, 1'b0, 5'd9,  3'd5, 10'h020, 32'hf8000000},
    '{32'h7ffffff0, 32'h00000021, alu_sra,    1'b0, 1'b0, 5'd10, 3'd5, 10'h020, 32'h3ffffff8},
    // signed against unsigned compares
    '{32'hffffffff, 32'h00000001, alu_slt,    1'b0, 1'b0, 5'd11, 3'd2, 10'h020, 32'h00000001},
    '{32'hffffffff, 32'h00000001, alu_sltu,   1'b0, 1'b0, 5'd12, 3'd3, 10'h020, 32'h00000000},
    '{32'h00000005, 32'h00000003, alu_slt,    1'b1, 1'b0, 5'd0,  3'd5, 10'h002, 32'h00000001},
    '{32'h00000001, 32'hffffffff, alu_sltu,   1'b1, 1'b0, 5'd0,  3'd7, 10'h002, 32'h00000000},
    '{32'h80000000, 32'h7fffffff, alu_slt,    1'b0, 1'b0, 5'd13, 3'd2, 10'h020, 32'h00000001},
    '{32'h80000000, 32'h7fffffff, alu_sltu,   1'b0, 1'b0, 5'd14, 3'd3, 10'h020, 32'h00000000},
    // logic ops and lui
    '{32'ha5a5a5a5, 32'hffff0000, alu_xor,    1'b0, 1'b0, 5'd15, 3'd4, 10'h020, 32'h5a5aa5a5},
    '{32'h12340000, 32'h00005678, alu_or,     1'b0, 1'b0, 5'd16, 3'd6, 10'h020, 32'h12345678},
    '{32'hf0f0f0f0, 32'h3c3c3c3c, alu_and,    1'b0, 1'b0, 5'd17, 3'd7, 10'h020, 32'h30303030},
    '{32'hdeadbeef, 32'h12345000, alu_pass_b, 1'b0, 1'b0, 5'd18, 3'd0, 10'h020, 32'h12345000},
    // memory, branch, jump, csr and fence.i controls, some killed
    '{32'h00000100, 32'h00000020, alu_add,    1'b0, 1'b1, 5'd19, 3'd2, 10'h010, 32'h00000120},
    '{32'h00001000, 32'h00000008, alu_add,    1'b0, 1'b0, 5'd0,  3'd2, 10'h010, 32'h00001008},
    '{32'h00002000, 32'hfffffffc, alu_add,    1'b0, 1'b0, 5'd20, 3'd2, 10'h028, 32'h00001ffc},
    '{32'h00000009, 32'h00000009, alu_sub,    1'b0, 1'b1, 5'd0,  3'd0, 10'h002, 32'h00000000},
    '{32'h00000400, 32'h00000004, alu_add,    1'b0, 1'b0, 5'd1,  3'd0, 10'h024, 32'h00000404},
    '{32'h0000000f, 32'h000000f0, alu_or,     1'b0, 1'b1, 5'd21, 3'd1, 10'h060, 32'h000000ff},
    '{32'h00000000, 32'h00000000, alu_add,    1'b0, 1'b0, 5'd0,  3'd1, 10'h001, 32'h00000000},
    '{32'h0000000f, 32'h000000f0, alu_or,     1'b0, 1'b0, 5'd22, 3'd1, 10'h060, 32'h000000ff}
};

//--- sim/exu_tb.sv
`timescale 1ns/100ps

module exu_tb;

    import isa_pkg::*;
    import pipe_pkg::*;

    `include "exu_vectors.svh"

    localparam int wait_limit  = 100;   // cycles per handshake wait
    localparam int drain_limit = wait_limit * n_vec;

    logic                   clock = 1'b0;
    logic                   reset = 1'b1;
    logic                   valid_in = 1'b0;
    logic                   ready_out = 1'b0;
    logic                   inst_kill = 1'b0;
    logic [xlen-1:0]        op1 = '0;
    logic [xlen-1:0]        op2 = '0;
    alu_op_t                alu_op = alu_add;
    logic                   inv_flag = 1'b0;
    logic [reg_idx_w-1:0]   rd = '0;
    logic [funct3_w-1:0]    funct3 = '0;
    logic [xlen-1:0]        imm = '0;
    logic [xlen-1:0]        rs2_value = '0;
    logic [xlen-1:0]        rd_value = '0;
    logic [csr_wen_w-1:0]   csr_wen = '0;
    logic                   reg_wen = 1'b0;
    logic                   mem_wen = 1'b0;
    logic                   mem_ren = 1'b0;
    logic                   jump_flag = 1'b0;
    logic                   branch_flag = 1'b0;
    logic                   fetch_i_flag = 1'b0;

    logic                   ready_in;
    logic                   valid_out;
    logic [xlen-1:0]        ex_result;
    logic [reg_idx_w-1:0]   rd_out;
    logic [funct3_w-1:0]    funct3_out;
    logic [xlen-1:0]        imm_out;
    logic [xlen-1:0]        rs2_value_out;
    logic [xlen-1:0]        rd_value_out;
    logic [csr_wen_w-1:0]   csr_wen_out;
    logic                   reg_wen_out;
    logic                   mem_wen_out;
    logic                   mem_ren_out;
    logic                   jump_flag_out;
    logic                   branch_flag_out;
    logic                   fetch_i_flag_out;
    logic [perf_cnt_w-1:0]  exec_count;
    logic [perf_cnt_w-1:0]  kill_count;
    logic [perf_cnt_w-1:0]  stall_count;
    logic [csr_wen_w+5:0]   ctrl_out;   // same packing as the table's ctrl column

    int     error_count = 0;
    int     tests_ok = 0;
    int     tests_bad = 0;
    integer seed = 32'h28f9;

    assign ctrl_out = {csr_wen_out, reg_wen_out, mem_wen_out, mem_ren_out,
                       jump_flag_out, branch_flag_out, fetch_i_flag_out};

    always #10 clock = ~clock;

    exu dut_i (.*);

    // --------------------
    // reference model
    // --------------------
    function automatic logic [xlen-1:0] alu_model(alu_op_t op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b, logic inv);
        logic [xlen-1:0] r;
        int              sh;
        sh = int'(b[4:0]);
        case (op)
            alu_add:    r = a + b;
            alu_sub:    r = a + ~b + 32'd1;
            alu_sll:    r = a << sh;
            alu_srl:    r = a >> sh;
            alu_sra:    r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            alu_slt:    r = (a[31] != b[31]) ? 32'(a[31]) : 32'(a < b);   // sign decides first
            alu_sltu:   r = 32'(a < b);
            alu_xor:    r = a ^ b;
            alu_or:     r = a | b;
            alu_and:    r = a & b;
            alu_pass_b: r = b;
            default:    r = 32'd0;
        endcase
        r[0] = r[0] ^ inv;
        return r;
    endfunction

    // distinct pass-through payload per row
    function automatic logic [xlen-1:0] imm_of(int i);
        return 32'h0000_0800 + 32'(i) * 32'h0001_0003;
    endfunction

    function automatic void check_word(string name, logic [31:0] expected,
                                       logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endfunction

    function automatic void check_row(int i);
        check_word("ex_result", vectors[i].exp, ex_result);
        check_word("rd_out", 32'(vectors[i].rd), 32'(rd_out));
        check_word("funct3_out", 32'(vectors[i].funct3), 32'(funct3_out));
        check_word("imm_out", imm_of(i), imm_out);
        check_word("rs2_value_out", ~imm_of(i), rs2_value_out);
        check_word("rd_value_out", imm_of(i) ^ 32'hc3c3_3c3c, rd_value_out);
        check_word("side-effect controls", 32'(vectors[i].ctrl), 32'(ctrl_out));
    endfunction

    task automatic report_test(string name, int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: FAIL, %0d errors", name, error_count - errors_before);
            tests_bad++;
        end
    endtask

    task automatic present_row(int i);
        valid_in  <= 1'b1;
        inst_kill <= vectors[i].kill;
        op1       <= vectors[i].op1;
        op2       <= vectors[i].op2;
        alu_op    <= vectors[i].op;
        inv_flag  <= vectors[i].inv;
        rd        <= vectors[i].rd;
        funct3    <= vectors[i].funct3;
        imm       <= imm_of(i);
        rs2_value <= ~imm_of(i);
        rd_value  <= imm_of(i) ^ 32'hc3c3_3c3c;
        {csr_wen, reg_wen, mem_wen, mem_ren, jump_flag, branch_flag, fetch_i_flag}
            <= vectors[i].ctrl;
    endtask

    // --------------------
    // bounded waits
    // --------------------
    task automatic wait_for_ready();
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < wait_limit && !seen; n++) begin
            @(negedge clock);
            seen = ready_in;
        end
        if (!seen) begin
            $display("timeout: ready_in stayed low for %0d cycles", wait_limit);
            error_count++;
        end
    endtask

    task automatic wait_for_valid(output int cycles);
        int n;
        cycles = 0;
        for (n = 1; n <= wait_limit && cycles == 0; n++) begin
            @(negedge clock);
            if (valid_out)
                cycles = n;
        end
        if (cycles == 0) begin
            $display("timeout: valid_out did not rise within %0d cycles", wait_limit);
            error_count++;
        end
    endtask

    initial begin
        int                     i;
        int                     n;
        int                     errs;
        int                     sent;
        int                     accepted;
        int                     kills;
        int                     stalls;
        bit                     took;
        bit                     done;
        logic [31:0]            rnd;
        alu_op_t                op_i;
        logic [perf_cnt_w-1:0]  base_exec;
        logic [perf_cnt_w-1:0]  base_kill;
        logic [perf_cnt_w-1:0]  base_stall;
        int                     exp_q[$];

        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        errs = error_count;
        check_word("valid_out", 32'd0, 32'(valid_out));
        check_word("ready_in", 32'd1, 32'(ready_in));   // downstream not ready here
        check_word("exec_count", 32'd0, exec_count);
        check_word("kill_count", 32'd0, kill_count);
        check_word("stall_count", 32'd0, stall_count);
        report_test("reset state", errs);

        @(posedge clock);
        ready_out <= 1'b1;

        // one row at a time with downstream always ready
        for (i = 0; i < n_vec; i++) begin
            errs = error_count;
            op_i = vectors[i].op;
            check_word("vectors.exp", alu_model(vectors[i].op, vectors[i].op1,
                       vectors[i].op2, vectors[i].inv), vectors[i].exp);
            @(posedge clock);
            present_row(i);
            wait_for_ready();
            base_kill = kill_count;
            @(posedge clock);
            valid_in <= 1'b0;
            if (vectors[i].kill) begin
                @(negedge clock);
                check_word("valid_out", 32'd0, 32'(valid_out));
                check_word("side-effect controls", 32'd0, 32'(ctrl_out));
                check_word("kill_count", base_kill + 32'd1, kill_count);
            end else begin
                wait_for_valid(n);
                if (n != 0) begin
                    check_word("valid_out latency", 32'd1, 32'(n));
                    check_row(i);
                end
            end
            report_test($sformatf("row %0d %s%s%s", i, op_i.name(),
                        vectors[i].inv ? " inv" : "", vectors[i].kill ? " killed" : ""), errs);
        end

        // --------------------
        // random back-pressure
        // --------------------
        @(negedge clock);   // last directed item has left
        errs = error_count;
        base_exec  = exec_count;
        base_kill  = kill_count;
        base_stall = stall_count;
        sent = 0;
        accepted = 0;
        kills = 0;
        stalls = 0;
        n = 0;
        done = 1'b0;
        @(posedge clock);
        present_row(0);
        while (!done && n < drain_limit) begin
            @(negedge clock);
            n++;
            if (valid_out && !ready_out)
                stalls++;
            if (valid_out) begin
                if (exp_q.size() == 0) begin
                    $display("valid_out high at %0t with no instruction outstanding", $time);
                    error_count++;
                end else begin
                    check_row(exp_q[0]);   // also holds every stalled cycle
                    if (ready_out)
                        void'(exp_q.pop_front());
                end
            end
            took = valid_in && ready_in;
            if (took) begin
                if (vectors[sent].kill) begin
                    kills++;
                end else begin
                    exp_q.push_back(sent);
                    accepted++;
                end
                sent++;
            end
            done = (sent == n_vec) && (exp_q.size() == 0);
            @(posedge clock);
            if (took && sent < n_vec)
                present_row(sent);
            else if (took)
                valid_in <= 1'b0;
            rnd = $random(seed);
            ready_out <= (rnd[1:0] != 2'b00);
        end
        if (!done) begin
            $display("timeout: back-pressure run did not drain within %0d cycles", drain_limit);
            error_count++;
        end
        @(negedge clock);
        check_word("exec_count", 32'(accepted), exec_count - base_exec);
        check_word("kill_count", 32'(kills), kill_count - base_kill);
        check_word("stall_count", 32'(stalls), stall_count - base_stall);
        report_test("random back-pressure", errs);

        $display("tests run %0d, ok %0d, failing %0d, check errors %0d",
                 tests_ok + tests_bad, tests_ok, tests_bad, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src/exu.sv
`timescale 1ns/100ps

module exu (
    input  logic                              clock,
    input  logic                              reset,

    // upstream
    input  logic                              valid_in,
    output logic                              ready_in,
    input  logic                              inst_kill,

    // operands and alu control
    input  logic [isa_pkg::xlen-1:0]          op1,
    input  logic [isa_pkg::xlen-1:0]          op2,
    input  isa_pkg::alu_op_t                  alu_op,
    input  logic                              inv_flag,

    // carried along to the memory stage
    input  logic [isa_pkg::reg_idx_w-1:0]     rd,
    input  logic [isa_pkg::funct3_w-1:0]      funct3,
    input  logic [isa_pkg::xlen-1:0]          imm,
    input  logic [isa_pkg::xlen-1:0]          rs2_value,
    input  logic [isa_pkg::xlen-1:0]          rd_value,
    input  logic [pipe_pkg::csr_wen_w-1:0]    csr_wen,
    input  logic                              reg_wen,
    input  logic                              mem_wen,
    input  logic                              mem_ren,
    input  logic                              jump_flag,
    input  logic                              branch_flag,
    input  logic                              fetch_i_flag,

    // downstream
    output logic                              valid_out,
    input  logic                              ready_out,
    output logic [isa_pkg::xlen-1:0]          ex_result,
    output logic [isa_pkg::reg_idx_w-1:0]     rd_out,
    output logic [isa_pkg::funct3_w-1:0]      funct3_out,
    output logic [isa_pkg::xlen-1:0]          imm_out,
    output logic [isa_pkg::xlen-1:0]          rs2_value_out,
    output logic [isa_pkg::xlen-1:0]          rd_value_out,
    output logic [pipe_pkg::csr_wen_w-1:0]    csr_wen_out,
    output logic                              reg_wen_out,
    output logic                              mem_wen_out,
    output logic                              mem_ren_out,
    output logic                              jump_flag_out,
    output logic                              branch_flag_out,
    output logic                              fetch_i_flag_out,

    // perf
    output logic [pipe_pkg::perf_cnt_w-1:0]   exec_count,
    output logic [pipe_pkg::perf_cnt_w-1:0]   kill_count,
    output logic [pipe_pkg::perf_cnt_w-1:0]   stall_count
);

    logic capture;
    logic kill_capture;

    exu_handshake handshake_i (
        .clock        (clock),
        .reset        (reset),
        .valid_in     (valid_in),
        .ready_out    (ready_out),
        .inst_kill    (inst_kill),
        .ready_in     (ready_in),
        .valid_out    (valid_out),
        .capture      (capture),
        .kill_capture (kill_capture)
    );

    exu_operand_stage operand_i (
        .clock     (clock),
        .reset     (reset),
        .capture   (capture),
        .op1       (op1),
        .op2       (op2),
        .alu_op    (alu_op),
        .inv_flag  (inv_flag),
        .ex_result (ex_result)
    );

    exu_sideband sideband_i (
        .clock            (clock),
        .reset            (reset),
        .capture          (capture),
        .kill_capture     (kill_capture),
        .rd               (rd),
        .funct3           (funct3),
        .imm              (imm),
        .rs2_value        (rs2_value),
        .rd_value         (rd_value),
        .csr_wen          (csr_wen),
        .reg_wen          (reg_wen),
        .mem_wen          (mem_wen),
        .mem_ren          (mem_ren),
        .jump_flag        (jump_flag),
        .branch_flag      (branch_flag),
        .fetch_i_flag     (fetch_i_flag),
        .rd_out           (rd_out),
        .funct3_out       (funct3_out),
        .imm_out          (imm_out),
        .rs2_value_out    (rs2_value_out),
        .rd_value_out     (rd_value_out),
        .csr_wen_out      (csr_wen_out),
        .reg_wen_out      (reg_wen_out),
        .mem_wen_out      (mem_wen_out),
        .mem_ren_out      (mem_ren_out),
        .jump_flag_out    (jump_flag_out),
        .branch_flag_out  (branch_flag_out),
        .fetch_i_flag_out (fetch_i_flag_out)
    );

    exu_perf perf_i (
        .clock        (clock),
        .reset        (reset),
        .capture      (capture),
        .kill_capture (kill_capture),
        .valid_out    (valid_out),
        .ready_out    (ready_out),
        .exec_count   (exec_count),
        .kill_count   (kill_count),
        .stall_count  (stall_count)
    );

endmodule

//--- src/exu_perf.sv
`timescale 1ns/100ps

module exu_perf (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              capture,
    input  logic                              kill_capture,
    input  logic                              valid_out,
    input  logic                              ready_out,
    output logic [pipe_pkg::perf_cnt_w-1:0]   exec_count,
    output logic [pipe_pkg::perf_cnt_w-1:0]   kill_count,
    output logic [pipe_pkg::perf_cnt_w-1:0]   stall_count
);

    logic exec_evt;
    logic stall_evt;

    assign exec_evt  = capture & ~kill_capture;
    assign stall_evt = valid_out & ~ready_out;   // held by back-pressure

    // --------------------
    // counters
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exec_count  <= '0;
            kill_count  <= '0;
            stall_count <= '0;
        end else begin
            if (exec_evt)
                exec_count <= exec_count + 1'b1;
            if (kill_capture)
                kill_count <= kill_count + 1'b1;
            if (stall_evt)
                stall_count <= stall_count + 1'b1;
        end
    end

endmodule

//--- src/exu_sideband.sv
`timescale 1ns/100ps

module exu_sideband (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             capture,
    input  logic                             kill_capture,
    input  logic [isa_pkg::reg_idx_w-1:0]    rd,
    input  logic [isa_pkg::funct3_w-1:0]     funct3,
    input  logic [isa_pkg::xlen-1:0]         imm,
    input  logic [isa_pkg::xlen-1:0]         rs2_value,
    input  logic [isa_pkg::xlen-1:0]         rd_value,
    input  logic [pipe_pkg::csr_wen_w-1:0]   csr_wen,
    input  logic                             reg_wen,
    input  logic                             mem_wen,
    input  logic                             mem_ren,
    input  logic                             jump_flag,
    input  logic                             branch_flag,
    input  logic                             fetch_i_flag,
    output logic [isa_pkg::reg_idx_w-1:0]    rd_out,
    output logic [isa_pkg::funct3_w-1:0]     funct3_out,
    output logic [isa_pkg::xlen-1:0]         imm_out,
    output logic [isa_pkg::xlen-1:0]         rs2_value_out,
    output logic [isa_pkg::xlen-1:0]         rd_value_out,
    output logic [pipe_pkg::csr_wen_w-1:0]   csr_wen_out,
    output logic                             reg_wen_out,
    output logic                             mem_wen_out,
    output logic                             mem_ren_out,
    output logic                             jump_flag_out,
    output logic                             branch_flag_out,
    output logic                             fetch_i_flag_out
);

    import pipe_pkg::*;

    localparam int ctrl_w = csr_wen_w + 6;

    logic [ctrl_w-1:0] ctrl_in;
    logic [ctrl_w-1:0] ctrl_q;

    assign ctrl_in = {csr_wen, reg_wen, mem_wen, mem_ren, jump_flag, branch_flag, fetch_i_flag};

    // --------------------
    // pass-through fields
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_out        <= '0;
            funct3_out    <= '0;
            imm_out       <= '0;
            rs2_value_out <= '0;
            rd_value_out  <= '0;
        end else if (capture) begin
            rd_out        <= rd;
            funct3_out    <= funct3;
            imm_out       <= imm;
            rs2_value_out <= rs2_value;
            rd_value_out  <= rd_value;
        end
    end

    // side-effect controls, squashed by the branch unit
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ctrl_q <= '0;
        end else if (capture) begin
            ctrl_q <= kill_capture ? '0 : ctrl_in;
        end
    end

    assign {csr_wen_out, reg_wen_out, mem_wen_out, mem_ren_out,
            jump_flag_out, branch_flag_out, fetch_i_flag_out} = ctrl_q;

    a_no_mem_rw: assert property (
        @(posedge clock) disable iff (reset)
        !(mem_wen_out && mem_ren_out)
    );

endmodule

//--- src/exu_operand_stage.sv
`timescale 1ns/100ps

module exu_operand_stage (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         capture,
    input  logic [isa_pkg::xlen-1:0]     op1,
    input  logic [isa_pkg::xlen-1:0]     op2,
    input  isa_pkg::alu_op_t             alu_op,
    input  logic                         inv_flag,
    output logic [isa_pkg::xlen-1:0]     ex_result
);

    import isa_pkg::*;

    logic [xlen-1:0] op1_q;
    logic [xlen-1:0] op2_q;
    alu_op_t         alu_op_q;
    logic            inv_q;
    logic [xlen-1:0] alu_res;

    // --------------------
    // operand registers
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            op1_q    <= '0;
            op2_q    <= '0;
            alu_op_q <= alu_add;
            inv_q    <= 1'b0;
        end else if (capture) begin
            op1_q    <= op1;
            op2_q    <= op2;
            alu_op_q <= alu_op;
            inv_q    <= inv_flag;
        end
    end

    alu alu_i (
        .op  (alu_op_q),
        .a   (op1_q),
        .b   (op2_q),
        .res (alu_res)
    );

    // flip the compare bit: slt -> bge, sltu -> bgeu
    assign ex_result = alu_res ^ {{(xlen-1){1'b0}}, inv_q};

    a_op_listed: assert property (
        @(posedge clock) disable iff (reset)
        capture |=> alu_op_q inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                     alu_xor, alu_srl, alu_sra, alu_or, alu_and,
                                     alu_pass_b}
    );

endmodule

//--- src/alu.sv
`timescale 1ns/100ps

module alu (
    input  isa_pkg::alu_op_t             op,
    input  logic [isa_pkg::xlen-1:0]     a,
    input  logic [isa_pkg::xlen-1:0]     b,
    output logic [isa_pkg::xlen-1:0]     res
);

    import isa_pkg::*;

    localparam int shamt_w = $clog2(xlen);

    logic [shamt_w-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [xlen-1:0]    sum;
    logic [xlen-1:0]    diff;

    assign shamt       = b[shamt_w-1:0];   // upper bits of b ignored
    assign sum         = a + b;
    assign diff        = a - b;
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:    res = sum;
            alu_sub:    res = diff;
            alu_sll:    res = a << shamt;
            alu_slt:    res = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   res = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    res = a ^ b;
            alu_srl:    res = a >> shamt;
            alu_sra:    res = $unsigned($signed(a) >>> shamt);
            alu_or:     res = a | b;
            alu_and:    res = a & b;
            alu_pass_b: res = b;
            default:    res = '0;   // unused encodings
        endcase
    end

endmodule

//--- src/exu_handshake.sv
`timescale 1ns/100ps

module exu_handshake (
    input  logic clock,
    input  logic reset,
    input  logic valid_in,
    input  logic ready_out,
    input  logic inst_kill,
    output logic ready_in,
    output logic valid_out,
    output logic capture,
    output logic kill_capture
);

    // room when empty or when the held item leaves this cycle
    assign ready_in     = ready_out | ~valid_out;
    assign capture      = valid_in & ready_in;
    assign kill_capture = capture & inst_kill;

    // valid of the stage register
    // a capture only lands in an empty or draining stage
    // so the kill alone decides what the stage holds next
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (capture) begin
            valid_out <= ~inst_kill;
        end else if (ready_out) begin
            valid_out <= 1'b0;   // transferred with nothing new behind it
        end
    end

    // --------------------
    // checks
    // --------------------
    // held item stays until the memory stage takes it
    a_hold_on_stall: assert property (
        @(posedge clock) disable iff (reset)
        valid_out && !ready_out |=> valid_out
    );

endmodule

//--- src/pipe_pkg.sv
package pipe_pkg;

    // --------------------
    // side-effect controls
    // --------------------
    // one enable per csr write kind (write, set, clear, mret)
    localparam int csr_wen_w = 4;

    // --------------------
    // performance counters
    // --------------------
    localparam int perf_cnt_w = 32;   // wraps, no saturation

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

    // --------------------
    // architectural widths
    // --------------------
    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;   // x0..x31
    localparam int funct3_w  = 3;
    localparam int alu_op_w  = 4;

    // --------------------
    // alu opcodes
    // --------------------
    // low three bits follow funct3, bit 3 picks the alternate form
    typedef enum logic [alu_op_w-1:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,
        alu_sra    = 4'b1101,
        alu_pass_b = 4'b1111    // lui style, b straight through
    } alu_op_t;

endpackage
